// ==== hdl/snake_geom_pkg.sv ====
package snake_geom_pkg;

    ////////////////////////////////////////////////////////////////////
    // Grid geometry
    ////////////////////////////////////////////////////////////////////

    // One grid coordinate in cells, wraps modulo 512
    typedef logic [8:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    // Opposite directions differ only in bit 0
    typedef enum logic [1:0] {
        DIR_UP    = 2'd0,
        DIR_DOWN  = 2'd1,
        DIR_LEFT  = 2'd2,
        DIR_RIGHT = 2'd3
    } dir_t;

    function automatic dir_t dir_opposite(dir_t d);
        return dir_t'({d[1], ~d[0]});
    endfunction

    // One cell in direction d, y grows downward
    function automatic point_t point_step(point_t p, dir_t d);
        point_t q;
        q = p;
        case (d)
            DIR_UP:    q.y = p.y - coord_t'(1);
            DIR_DOWN:  q.y = p.y + coord_t'(1);
            DIR_LEFT:  q.x = p.x - coord_t'(1);
            default:   q.x = p.x + coord_t'(1);
        endcase
        return q;
    endfunction

endpackage

// ==== hdl/snake_game_pkg.sv ====
package snake_game_pkg;

    ////////////////////////////////////////////////////////////////////
    // Game status
    ////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_RUN  = 2'd1,
        ST_OVER = 2'd2
    } game_state_t;

    // Snake length, holds up to 32 segments
    typedef logic [5:0] len_t;

    // Food eaten, saturates at the top
    typedef logic [7:0] score_t;

    localparam score_t SCORE_MAX = '1;

endpackage

// ==== hdl/game_ctrl.sv ====
`timescale 1ns/1ps

module game_ctrl
    import snake_geom_pkg::*;
    import snake_game_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  logic        step,
    input  dir_t        dir_req,
    input  logic        bite,
    input  logic        dead,
    output logic        init,
    output logic        move,
    output dir_t        cur_dir,
    output game_state_t state,
    output score_t      score
);

    game_state_t state_next;
    logic        step_ok;

    assign step_ok = step && (state == ST_RUN);

    ////////////////////////////////////////////////////////////////////
    // Game FSM
    ////////////////////////////////////////////////////////////////////

    // Run begins together with the body and food reload
    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: if (init) state_next = ST_RUN;
            ST_RUN:  if (dead) state_next = ST_OVER;
            ST_OVER: if (init) state_next = ST_RUN;
            default: state_next = ST_IDLE;
        endcase
    end

    // Start is a level, so init fires once per accepted start
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
            init  <= 1'b0;
            move  <= 1'b0;
        end else begin
            state <= state_next;
            init  <= start && (state != ST_RUN) && !init;
            move  <= step_ok;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Direction and score
    ////////////////////////////////////////////////////////////////////

    // Latched with the step so the body sees it on move
    always_ff @(posedge clk) begin
        if (reset || init) begin
            cur_dir <= DIR_RIGHT;
        end else if (step_ok && (dir_req != dir_opposite(cur_dir))) begin
            cur_dir <= dir_req;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || init) begin
            score <= '0;
        end else if (bite && (score != SCORE_MAX)) begin
            score <= score + score_t'(1);
        end
    end

endmodule

// ==== hdl/snake_body.sv ====
`timescale 1ns/1ps

module snake_body
    import snake_geom_pkg::*;
    import snake_game_pkg::*;
#(
    parameter int MAX_LEN   = 32,
    parameter int START_LEN = 3,
    parameter int START_X   = 20,
    parameter int START_Y   = 20
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   init,
    input  logic   move,
    input  dir_t   cur_dir,
    input  logic   grow,
    output point_t segs [MAX_LEN],
    output len_t   length,
    output logic   moved
);

    // Bite seen, waiting for the next move
    logic   grow_pend;
    point_t head_next;

    assign head_next = point_step(segs[0], cur_dir);

    ////////////////////////////////////////////////////////////////////
    // Segment shift register
    ////////////////////////////////////////////////////////////////////

    // Start position has the body trailing off to the left
    always_ff @(posedge clk) begin
        if (reset || init) begin
            for (int i = 0; i < MAX_LEN; i++) begin
                segs[i].x <= coord_t'(START_X - i);
                segs[i].y <= coord_t'(START_Y);
            end
        end else if (move) begin
            segs[0] <= head_next;
            for (int i = 1; i < MAX_LEN; i++) begin
                segs[i] <= segs[i-1];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Length and growth
    ////////////////////////////////////////////////////////////////////

    // The old tail shifts into index length, so growing keeps it
    always_ff @(posedge clk) begin
        if (reset || init) begin
            length    <= len_t'(START_LEN);
            grow_pend <= 1'b0;
        end else begin
            if (grow) begin
                grow_pend <= 1'b1;
            end
            if (move && grow_pend) begin
                grow_pend <= 1'b0;
                if (int'(length) < MAX_LEN) begin
                    length <= length + len_t'(1);
                end
            end
        end
    end

    // Marks the cycle the new head is visible
    always_ff @(posedge clk) begin
        if (reset) begin
            moved <= 1'b0;
        end else begin
            moved <= move;
        end
    end

endmodule

// ==== hdl/snake_collision.sv ====
`timescale 1ns/1ps

module snake_collision
    import snake_geom_pkg::*;
    import snake_game_pkg::*;
#(
    parameter int GRID_W  = 500,
    parameter int GRID_H  = 400,
    parameter int MAX_LEN = 32
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   moved,
    input  point_t segs [MAX_LEN],
    input  len_t   length,
    input  point_t food,
    output logic   bite,
    output logic   dead
);

    logic wall_hit;
    logic body_hit;

    // Left and top edges wrap to large values, so one compare per axis
    assign wall_hit = (int'(segs[0].x) >= GRID_W) || (int'(segs[0].y) >= GRID_H);

    // Segments 1 to 3 can never reach the head
    always_comb begin
        body_hit = 1'b0;
        for (int i = 4; i < MAX_LEN; i++) begin
            if ((i < int'(length)) && (segs[i] == segs[0])) begin
                body_hit = 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Registered result, one pulse per move
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            bite <= 1'b0;
            dead <= 1'b0;
        end else begin
            bite <= moved && (segs[0] == food);
            dead <= moved && (wall_hit || body_hit);
        end
    end

endmodule

// ==== hdl/food_placer.sv ====
`timescale 1ns/1ps

module food_placer
    import snake_geom_pkg::*;
#(
    parameter int GRID_W  = 500,
    parameter int GRID_H  = 400,
    parameter int FOOD_X0 = 40,
    parameter int FOOD_Y0 = 20
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   init,
    input  logic   bite,
    output point_t food
);

    // Any nonzero value keeps the sequence alive
    localparam logic [31:0] LFSR_SEED = 32'hc3a5_1e6b;

    logic [31:0] lfsr;
    logic        lfsr_fb;
    point_t      food_new;

    ////////////////////////////////////////////////////////////////////
    // Free-running random source
    ////////////////////////////////////////////////////////////////////

    // Taps for x^32 + x^22 + x^2 + x + 1
    assign lfsr_fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {lfsr[30:0], lfsr_fb};
        end
    end

    // Low half picks the column, high half the row
    assign food_new.x = coord_t'(32'(lfsr[15:0]) % GRID_W);
    assign food_new.y = coord_t'(32'(lfsr[31:16]) % GRID_H);

    always_ff @(posedge clk) begin
        if (reset || init) begin
            food.x <= coord_t'(FOOD_X0);
            food.y <= coord_t'(FOOD_Y0);
        end else if (bite) begin
            food <= food_new;
        end
    end

endmodule

// ==== hdl/snake_game_top.sv ====
`timescale 1ns/1ps

module snake_game_top
    import snake_geom_pkg::*;
    import snake_game_pkg::*;
#(
    parameter int GRID_W    = 500,
    parameter int GRID_H    = 400,
    parameter int MAX_LEN   = 32,
    parameter int START_LEN = 3,
    parameter int START_X   = 20,
    parameter int START_Y   = 20,
    parameter int FOOD_X0   = 40,
    parameter int FOOD_Y0   = 20
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  logic        step,
    input  dir_t        dir_req,
    output point_t      head,
    output point_t      food,
    output len_t        length,
    output score_t      score,
    output game_state_t state,
    output logic        bite,
    output logic        dead
);

    logic   init;
    logic   move;
    logic   moved;
    dir_t   cur_dir;
    point_t segs [MAX_LEN];

    assign head = segs[0];

    game_ctrl u_ctrl (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .step    (step),
        .dir_req (dir_req),
        .bite    (bite),
        .dead    (dead),
        .init    (init),
        .move    (move),
        .cur_dir (cur_dir),
        .state   (state),
        .score   (score)
    );

    snake_body #(
        .MAX_LEN   (MAX_LEN),
        .START_LEN (START_LEN),
        .START_X   (START_X),
        .START_Y   (START_Y)
    ) u_body (
        .clk     (clk),
        .reset   (reset),
        .init    (init),
        .move    (move),
        .cur_dir (cur_dir),
        .grow    (bite),
        .segs    (segs),
        .length  (length),
        .moved   (moved)
    );

    // Head checks one cycle after each shift
    snake_collision #(
        .GRID_W  (GRID_W),
        .GRID_H  (GRID_H),
        .MAX_LEN (MAX_LEN)
    ) u_coll (
        .clk    (clk),
        .reset  (reset),
        .moved  (moved),
        .segs   (segs),
        .length (length),
        .food   (food),
        .bite   (bite),
        .dead   (dead)
    );

    food_placer #(
        .GRID_W  (GRID_W),
        .GRID_H  (GRID_H),
        .FOOD_X0 (FOOD_X0),
        .FOOD_Y0 (FOOD_Y0)
    ) u_food (
        .clk   (clk),
        .reset (reset),
        .init  (init),
        .bite  (bite),
        .food  (food)
    );

endmodule

// ==== bench/tb_snake_game.sv ====
`timescale 1ns/1ps

module tb_snake_game
    import snake_geom_pkg::*;
    import snake_game_pkg::*;
();

    localparam int GRID_W      = 500;
    localparam int GRID_H      = 400;
    localparam int MAX_LEN     = 32;
    localparam int START_LEN   = 5;
    localparam int START_X     = 10;
    localparam int START_Y     = 10;
    localparam int FOOD_X0     = 12;
    localparam int FOOD_Y0     = 10;
    localparam int CLK_PERIOD  = 8;
    localparam int STEP_GAP    = 8;
    localparam int RAND_STEPS  = 300;
    localparam int MAX_STEPS   = RAND_STEPS + 40;
    localparam int WATCHDOG_NS = (MAX_STEPS * STEP_GAP + 100) * CLK_PERIOD;
    localparam logic [31:0] RNG_SEED = 32'h6ad897f3;

    typedef struct packed {
        point_t head;
        logic   bite;
        logic   dead;
    } step_exp_t;

    logic        clk;
    logic        reset;
    logic        start;
    logic        step;
    dir_t        dir_req;
    point_t      head;
    point_t      food;
    len_t        length;
    score_t      score;
    game_state_t state;
    logic        bite;
    logic        dead;

    // Reference snake
    point_t      m_segs [MAX_LEN];
    int          m_len;
    dir_t        m_dir;
    score_t      m_score;
    game_state_t m_state;
    logic        m_grow;
    point_t      m_food;

    // Expected response to the latest step
    point_t      exp_head;
    point_t      exp_food;
    logic        exp_bite;
    logic        exp_dead;
    int          exp_len;
    score_t      exp_score;
    game_state_t exp_state;

    int   value_errors = 0;
    int   other_errors = 0;
    event stepped;

    snake_game_top #(
        .GRID_W    (GRID_W),
        .GRID_H    (GRID_H),
        .MAX_LEN   (MAX_LEN),
        .START_LEN (START_LEN),
        .START_X   (START_X),
        .START_Y   (START_Y),
        .FOOD_X0   (FOOD_X0),
        .FOOD_Y0   (FOOD_Y0)
    ) dut0 (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .step    (step),
        .dir_req (dir_req),
        .head    (head),
        .food    (food),
        .length  (length),
        .score   (score),
        .state   (state),
        .bite    (bite),
        .dead    (dead)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run went past its time limit");
        $display("** FAIL **");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic is_reverse(dir_t a, dir_t b);
        return (a == DIR_UP    && b == DIR_DOWN)  || (a == DIR_DOWN  && b == DIR_UP) ||
               (a == DIR_LEFT  && b == DIR_RIGHT) || (a == DIR_RIGHT && b == DIR_LEFT);
    endfunction

    // Rows count downward, coordinates wrap at 512
    function automatic point_t next_head(point_t p, dir_t d);
        point_t q;
        q = p;
        case (d)
            DIR_UP:    q.y = p.y - 9'd1;
            DIR_DOWN:  q.y = p.y + 9'd1;
            DIR_LEFT:  q.x = p.x - 9'd1;
            default:   q.x = p.x + 9'd1;
        endcase
        return q;
    endfunction

    // Body after the move is the old list shifted by one
    function automatic step_exp_t predict_step(dir_t d, point_t food_now);
        step_exp_t r;
        int        new_len;
        r.head  = next_head(m_segs[0], d);
        new_len = m_len;
        if (m_grow && m_len < MAX_LEN) begin
            new_len = m_len + 1;
        end
        r.bite = (r.head == food_now);
        r.dead = (int'(r.head.x) >= GRID_W) || (int'(r.head.y) >= GRID_H);
        for (int i = 4; i < MAX_LEN; i++) begin
            if (i < new_len && m_segs[i-1] == r.head) begin
                r.dead = 1'b1;
            end
        end
        return r;
    endfunction

    task automatic model_restart();
        for (int i = 0; i < MAX_LEN; i++) begin
            m_segs[i].x = coord_t'(START_X - i);
            m_segs[i].y = coord_t'(START_Y);
        end
        m_len    = START_LEN;
        m_dir    = DIR_RIGHT;
        m_score  = '0;
        m_state  = ST_RUN;
        m_grow   = 1'b0;
        m_food.x = coord_t'(FOOD_X0);
        m_food.y = coord_t'(FOOD_Y0);
    endtask

    ////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////

    task automatic check_value(string name, logic [31:0] got, logic [31:0] want);
        assert (got == want) else begin
            value_errors++;
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, name, got, want);
        end
    endtask

    task automatic check_point(string name, point_t got, point_t want);
        assert (got == want) else begin
            value_errors++;
            $display("** Error at %0t ns: %s is (%0d,%0d), expected (%0d,%0d)",
                     $time, name, got.x, got.y, want.x, want.y);
        end
    endtask

    // Head after 2 edges, pulses after 3, score and food after 4
    initial begin
        forever begin
            @(stepped);
            repeat (2) @(negedge clk);
            check_point("head", head, exp_head);
            check_value("length", 32'(length), exp_len);
            @(negedge clk);
            check_value("bite", 32'(bite), 32'(exp_bite));
            check_value("dead", 32'(dead), 32'(exp_dead));
            @(negedge clk);
            check_value("bite", 32'(bite), 32'(0));
            check_value("dead", 32'(dead), 32'(0));
            check_value("score", 32'(score), 32'(exp_score));
            check_value("state", 32'(state), 32'(exp_state));
            if (exp_bite) begin
                assert ((int'(food.x) < GRID_W) && (int'(food.y) < GRID_H)) else begin
                    other_errors++;
                    $display("Error at %0t ns: new food (%0d,%0d) lies outside the grid",
                             $time, food.x, food.y);
                end
                // New food position comes from the port
                m_food = food;
            end else begin
                check_point("food", food, exp_food);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////

    // Called on a falling edge, returns STEP_GAP cycles later
    task automatic run_step(dir_t req);
        step_exp_t r;
        r = '0;
        if (m_state == ST_RUN) begin
            if (!is_reverse(req, m_dir)) begin
                m_dir = req;
            end
            r = predict_step(m_dir, m_food);
            for (int i = MAX_LEN - 1; i > 0; i--) begin
                m_segs[i] = m_segs[i-1];
            end
            m_segs[0] = r.head;
            if (m_grow) begin
                m_grow = 1'b0;
                if (m_len < MAX_LEN) begin
                    m_len++;
                end
            end
            if (r.bite) begin
                m_grow = 1'b1;
                if (m_score != 8'hff) begin
                    m_score = m_score + 8'd1;
                end
            end
            if (r.dead) begin
                m_state = ST_OVER;
            end
        end else begin
            r.head = m_segs[0];
        end
        exp_head  = r.head;
        exp_bite  = r.bite;
        exp_dead  = r.dead;
        exp_food  = m_food;
        exp_len   = m_len;
        exp_score = m_score;
        exp_state = m_state;
        step      = 1'b1;
        dir_req   = req;
        -> stepped;
        @(negedge clk);
        step = 1'b0;
        repeat (STEP_GAP - 1) @(negedge clk);
    endtask

    task automatic start_game();
        point_t food0;
        food0.x = coord_t'(FOOD_X0);
        food0.y = coord_t'(FOOD_Y0);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        repeat (3) @(negedge clk);
        model_restart();
        check_point("head", head, m_segs[0]);
        check_point("food", food, food0);
        check_value("length", 32'(length), START_LEN);
        check_value("state", 32'(state), 32'(ST_RUN));
        check_value("score", 32'(score), 32'(0));
    endtask

    initial begin
        logic [31:0] rng;
        int          n;
        reset   = 1'b1;
        start   = 1'b0;
        step    = 1'b0;
        dir_req = DIR_RIGHT;
        model_restart();
        m_state = ST_IDLE;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_value("state", 32'(state), 32'(ST_IDLE));
        // A step before start must not move anything
        run_step(DIR_DOWN);

        // Reversal ignored, then the food two cells right, then turn up
        start_game();
        run_step(DIR_LEFT);
        run_step(DIR_RIGHT);
        run_step(DIR_UP);

        // Left then down bites the body
        run_step(DIR_LEFT);
        run_step(DIR_DOWN);
        run_step(DIR_RIGHT);
        run_step(DIR_RIGHT);
        check_value("state", 32'(state), 32'(ST_OVER));

        // Leave through the left wall
        start_game();
        run_step(DIR_UP);
        n = 0;
        while (m_state == ST_RUN && n < 20) begin
            run_step(DIR_LEFT);
            n++;
        end
        check_value("state", 32'(state), 32'(ST_OVER));

        // Random walk until the model predicts the end
        start_game();
        rng = RNG_SEED;
        n   = 0;
        while (m_state == ST_RUN && n < RAND_STEPS) begin
            rng = xorshift32(rng);
            run_step(dir_t'(rng[1:0]));
            n++;
        end
        $display("Random walk ran %0d steps", n);

        repeat (10) @(negedge clk);
        $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== files.f ====
hdl/snake_geom_pkg.sv
hdl/snake_game_pkg.sv
hdl/game_ctrl.sv
hdl/snake_body.sv
hdl/snake_collision.sv
hdl/food_placer.sv
hdl/snake_game_top.sv
bench/tb_snake_game.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_snake_game
FILELIST  := files.f
OBJ_DIR   := obj_dir
PASS_MSG  := ** PASS **

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
